//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mem_access
FILELIST  = mem_access_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = >>> FAIL

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: compile
	./$(OBJ_DIR)/$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q -F "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- mem_access_pkg.sv
package mem_access_pkg;

	// **************************************************
	// Widths and store geometry
	// **************************************************

	localparam int CPU_ADDR_BITS = 32;
	localparam int LINE_BITS = 256;

	// Bytes within a line sit below this bit.
	localparam int LINE_INDEX_LSB = 5;
	localparam int LINE_INDEX_BITS = 4;
	localparam int LINE_INDEX_MSB = LINE_INDEX_LSB + LINE_INDEX_BITS - 1;

	localparam int LINE_COUNT = 16;
	localparam int READ_LATENCY = 2; // Store rd_en to rd_valid.

	// **************************************************
	// Types
	// **************************************************

	typedef logic [CPU_ADDR_BITS-1:0] cpu_addr_t;
	typedef logic [LINE_BITS-1:0] line_data_t;
	typedef logic [LINE_INDEX_BITS-1:0] line_index_t;

	// Shared by the read and write holders.
	typedef enum logic
	{
		FIFO_IDLE,
		FIFO_WAIT_MEM
	} fifo_state_t;

	typedef enum logic [1:0]
	{
		GUARD_IDLE,
		GUARD_READ,
		GUARD_WRITE
	} guard_state_t;

	// Line number of a byte address.
	function automatic line_index_t line_index_of(input cpu_addr_t addr);
		return addr[LINE_INDEX_MSB:LINE_INDEX_LSB];
	endfunction

endpackage

//--- mem_access_properties.sv
module mem_access_properties
	import mem_access_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic rd_cmd_accepted,
	input logic wr_cmd_accepted,
	input logic store_rd_en,
	input logic store_rd_valid,
	input logic rd_busy,
	input logic rd_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	// **************************************************
	// Guard strobes
	// **************************************************

	rd_accept_single: assert property (@(posedge clk) disable iff (!arst_n)
		rd_cmd_accepted |=> !rd_cmd_accepted)
	else
	begin
		fail_count++;
		$error("rd_cmd_accepted high for more than one cycle");
	end

	wr_accept_single: assert property (@(posedge clk) disable iff (!arst_n)
		wr_cmd_accepted |=> !wr_cmd_accepted)
	else
	begin
		fail_count++;
		$error("wr_cmd_accepted high for more than one cycle");
	end

	accept_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(rd_cmd_accepted && wr_cmd_accepted))
	else
	begin
		fail_count++;
		$error("both accept pulses high together");
	end

	// Store latency in both directions.
	rd_latency_fwd: assert property (@(posedge clk) disable iff (!arst_n)
		store_rd_en |-> ##READ_LATENCY store_rd_valid)
	else
	begin
		fail_count++;
		$error("store_rd_valid missing after store_rd_en");
	end

	rd_latency_back: assert property (@(posedge clk) disable iff (!arst_n)
		store_rd_valid |-> $past(store_rd_en, READ_LATENCY))
	else
	begin
		fail_count++;
		$error("store_rd_valid without matching store_rd_en");
	end

	// Holder side.
	valid_not_busy: assert property (@(posedge clk) disable iff (!arst_n)
		!(rd_valid && rd_busy))
	else
	begin
		fail_count++;
		$error("rd_valid high while rd_busy high");
	end

endmodule

bind mem_access_top mem_access_properties i_mem_access_properties
(
	.clk             (clk),
	.arst_n          (arst_n),
	.rd_cmd_accepted (rd_cmd_accepted),
	.wr_cmd_accepted (wr_cmd_accepted),
	.store_rd_en     (store_rd_en),
	.store_rd_valid  (store_rd_valid),
	.rd_busy         (rd_busy),
	.rd_valid        (rd_valid)
);

//--- mem_access_top.f
mem_access_pkg.sv
mem_read_fifo.sv
mem_write_fifo.sv
mem_bus_guard.sv
mem_line_store.sv
mem_access_top.sv
mem_access_properties.sv
tb_mem_access.sv

//--- mem_access_top.sv
module mem_access_top
	import mem_access_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,

	// Read side.
	input  logic       req_read,
	input  cpu_addr_t  rd_addr,
	output logic       rd_busy,
	output logic       rd_valid,
	output line_data_t rd_data,

	// Write side.
	input  logic       req_write,
	input  cpu_addr_t  wr_addr,
	input  line_data_t wr_data,
	output logic       wr_busy,
	output logic       wr_done
);

	// **************************************************
	// Holder to guard
	// **************************************************

	logic guard_rd_req;
	cpu_addr_t guard_rd_addr;
	logic rd_cmd_accepted;
	logic rd_line_valid;
	line_data_t rd_line_data;

	logic guard_wr_req;
	cpu_addr_t guard_wr_addr;
	line_data_t guard_wr_data;
	logic wr_cmd_accepted;
	logic wr_line_done;

	// **************************************************
	// Guard to store
	// **************************************************

	logic store_rd_en;
	logic store_wr_en;
	line_index_t store_index;
	line_data_t store_wr_data;
	logic store_rd_valid;
	line_data_t store_rd_data;

	mem_read_fifo i_mem_read_fifo
	(
		.clk             (clk),
		.arst_n          (arst_n),
		.req_read        (req_read),
		.rd_addr         (rd_addr),
		.rd_busy         (rd_busy),
		.rd_valid        (rd_valid),
		.rd_data         (rd_data),
		.guard_rd_req    (guard_rd_req),
		.guard_rd_addr   (guard_rd_addr),
		.rd_cmd_accepted (rd_cmd_accepted),
		.rd_line_valid   (rd_line_valid),
		.rd_line_data    (rd_line_data)
	);

	mem_write_fifo i_mem_write_fifo
	(
		.clk             (clk),
		.arst_n          (arst_n),
		.req_write       (req_write),
		.wr_addr         (wr_addr),
		.wr_data         (wr_data),
		.wr_busy         (wr_busy),
		.wr_done         (wr_done),
		.guard_wr_req    (guard_wr_req),
		.guard_wr_addr   (guard_wr_addr),
		.guard_wr_data   (guard_wr_data),
		.wr_cmd_accepted (wr_cmd_accepted),
		.wr_line_done    (wr_line_done)
	);

	mem_bus_guard i_mem_bus_guard
	(
		.clk             (clk),
		.arst_n          (arst_n),
		.guard_rd_req    (guard_rd_req),
		.guard_rd_addr   (guard_rd_addr),
		.rd_cmd_accepted (rd_cmd_accepted),
		.rd_line_valid   (rd_line_valid),
		.rd_line_data    (rd_line_data),
		.guard_wr_req    (guard_wr_req),
		.guard_wr_addr   (guard_wr_addr),
		.guard_wr_data   (guard_wr_data),
		.wr_cmd_accepted (wr_cmd_accepted),
		.wr_line_done    (wr_line_done),
		.store_rd_en     (store_rd_en),
		.store_wr_en     (store_wr_en),
		.store_index     (store_index),
		.store_wr_data   (store_wr_data),
		.store_rd_valid  (store_rd_valid),
		.store_rd_data   (store_rd_data)
	);

	mem_line_store i_mem_line_store
	(
		.clk            (clk),
		.arst_n         (arst_n),
		.store_rd_en    (store_rd_en),
		.store_wr_en    (store_wr_en),
		.store_index    (store_index),
		.store_wr_data  (store_wr_data),
		.store_rd_valid (store_rd_valid),
		.store_rd_data  (store_rd_data)
	);

endmodule

//--- mem_bus_guard.sv
module mem_bus_guard
	import mem_access_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,

	// Read holder.
	input  logic        guard_rd_req,
	input  cpu_addr_t   guard_rd_addr,
	output logic        rd_cmd_accepted,
	output logic        rd_line_valid,
	output line_data_t  rd_line_data,

	// Write holder.
	input  logic        guard_wr_req,
	input  cpu_addr_t   guard_wr_addr,
	input  line_data_t  guard_wr_data,
	output logic        wr_cmd_accepted,
	output logic        wr_line_done,

	// Line store.
	output logic        store_rd_en,
	output logic        store_wr_en,
	output line_index_t store_index,
	output line_data_t  store_wr_data,
	input  logic        store_rd_valid,
	input  line_data_t  store_rd_data
);

	guard_state_t state;
	logic grant_rd;
	logic grant_wr;
	logic rd_return;
	line_index_t next_index;

	// **************************************************
	// Arbitration
	// **************************************************

	// Fixed priority, reads first.
	assign grant_rd = (state == GUARD_IDLE) && guard_rd_req;
	assign grant_wr = (state == GUARD_IDLE) && !guard_rd_req && guard_wr_req;

	assign next_index = grant_rd ? line_index_of(guard_rd_addr)
		: line_index_of(guard_wr_addr);

	assign rd_return = (state == GUARD_READ) && store_rd_valid;

	// **************************************************
	// Sequencer
	// **************************************************

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= GUARD_IDLE;
			rd_cmd_accepted <= 1'b0;
			wr_cmd_accepted <= 1'b0;
			rd_line_valid <= 1'b0;
			wr_line_done <= 1'b0;
			store_rd_en <= 1'b0;
			store_wr_en <= 1'b0;
		end
		else
		begin
			// All strobes are single cycle.
			rd_cmd_accepted <= 1'b0;
			wr_cmd_accepted <= 1'b0;
			rd_line_valid <= 1'b0;
			wr_line_done <= 1'b0;
			store_rd_en <= 1'b0;
			store_wr_en <= 1'b0;

			case (state)
			GUARD_IDLE:
			begin
				if (grant_rd)
				begin
					state <= GUARD_READ;
					rd_cmd_accepted <= 1'b1;
					store_rd_en <= 1'b1;
				end
				else if (grant_wr)
				begin
					state <= GUARD_WRITE;
					wr_cmd_accepted <= 1'b1;
					store_wr_en <= 1'b1;
				end
			end

			GUARD_READ:
			begin
				if (rd_return)
				begin
					state <= GUARD_IDLE;
					rd_line_valid <= 1'b1;
				end
			end

			// Store takes the write in one edge.
			GUARD_WRITE:
			begin
				state <= GUARD_IDLE;
				wr_line_done <= 1'b1;
			end

			default: state <= GUARD_IDLE;
			endcase
		end
	end

	// Command and return payload.
	always_ff @(posedge clk)
	begin
		if (grant_rd || grant_wr)
			store_index <= next_index;
		if (grant_wr)
			store_wr_data <= guard_wr_data;
		if (rd_return)
			rd_line_data <= store_rd_data;
	end

endmodule

//--- mem_line_store.sv
module mem_line_store
	import mem_access_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        store_rd_en,
	input  logic        store_wr_en,
	input  line_index_t store_index,
	input  line_data_t  store_wr_data,
	output logic        store_rd_valid,
	output line_data_t  store_rd_data
);

	line_data_t lines [LINE_COUNT];
	logic [READ_LATENCY-1:0] valid_sr;
	line_data_t data_sr [READ_LATENCY];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < LINE_COUNT; i++)
				lines[i] <= '0;
			valid_sr <= '0;
		end
		else
		begin
			if (store_wr_en)
				lines[store_index] <= store_wr_data;

			valid_sr[0] <= store_rd_en;
			for (int i = 1; i < READ_LATENCY; i++)
				valid_sr[i] <= valid_sr[i-1];
		end
	end

	// Read data follows the valid chain stage for stage.
	always_ff @(posedge clk)
	begin
		if (store_rd_en)
			data_sr[0] <= lines[store_index];
		for (int i = 1; i < READ_LATENCY; i++)
			data_sr[i] <= data_sr[i-1];
	end

	assign store_rd_valid = valid_sr[READ_LATENCY-1];
	assign store_rd_data = data_sr[READ_LATENCY-1];

endmodule

//--- mem_read_fifo.sv
module mem_read_fifo
	import mem_access_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,

	input  logic       req_read,
	input  cpu_addr_t  rd_addr,
	output logic       rd_busy,
	output logic       rd_valid,
	output line_data_t rd_data,

	output logic       guard_rd_req,
	output cpu_addr_t  guard_rd_addr,
	input  logic       rd_cmd_accepted,
	input  logic       rd_line_valid,
	input  line_data_t rd_line_data
);

	fifo_state_t state;
	logic cmd_was_accepted;
	logic start;
	logic line_taken;

	assign start = (state == FIFO_IDLE) && req_read;

	// Line may come back in the same cycle as the accept.
	assign line_taken = (state == FIFO_WAIT_MEM) && rd_line_valid
		&& (rd_cmd_accepted || cmd_was_accepted);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= FIFO_IDLE;
			cmd_was_accepted <= 1'b0;
			guard_rd_req <= 1'b0;
			rd_busy <= 1'b0;
			rd_valid <= 1'b0;
		end
		else
		begin
			case (state)
			FIFO_IDLE:
			begin
				rd_valid <= 1'b0;
				if (req_read)
				begin
					state <= FIFO_WAIT_MEM;
					guard_rd_req <= 1'b1;
					rd_busy <= 1'b1;
					cmd_was_accepted <= 1'b0;
				end
			end

			FIFO_WAIT_MEM:
			begin
				if (rd_cmd_accepted)
				begin
					cmd_was_accepted <= 1'b1;
					guard_rd_req <= 1'b0; // Guard has it now.
				end
				if (line_taken)
				begin
					state <= FIFO_IDLE;
					rd_valid <= 1'b1;
					rd_busy <= 1'b0;
				end
			end

			default: state <= FIFO_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			guard_rd_addr <= rd_addr;
		if (line_taken)
			rd_data <= rd_line_data;
	end

endmodule

//--- mem_write_fifo.sv
module mem_write_fifo
	import mem_access_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,

	input  logic       req_write,
	input  cpu_addr_t  wr_addr,
	input  line_data_t wr_data,
	output logic       wr_busy,
	output logic       wr_done,

	output logic       guard_wr_req,
	output cpu_addr_t  guard_wr_addr,
	output line_data_t guard_wr_data,
	input  logic       wr_cmd_accepted,
	input  logic       wr_line_done
);

	fifo_state_t state;
	logic cmd_was_accepted;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= FIFO_IDLE;
			cmd_was_accepted <= 1'b0;
			guard_wr_req <= 1'b0;
			wr_busy <= 1'b0;
			wr_done <= 1'b0;
		end
		else
		begin
			case (state)
			FIFO_IDLE:
			begin
				wr_done <= 1'b0;
				if (req_write)
				begin
					state <= FIFO_WAIT_MEM;
					guard_wr_req <= 1'b1;
					wr_busy <= 1'b1;
					cmd_was_accepted <= 1'b0;
				end
			end

			FIFO_WAIT_MEM:
			begin
				if (wr_cmd_accepted)
				begin
					cmd_was_accepted <= 1'b1;
					guard_wr_req <= 1'b0;
				end
				// Completion only counts once our command went out.
				if (wr_line_done && (wr_cmd_accepted || cmd_was_accepted))
				begin
					state <= FIFO_IDLE;
					wr_done <= 1'b1;
					wr_busy <= 1'b0;
				end
			end

			default: state <= FIFO_IDLE;
			endcase
		end
	end

	// Address and line held for the guard.
	always_ff @(posedge clk)
	begin
		if ((state == FIFO_IDLE) && req_write)
		begin
			guard_wr_addr <= wr_addr;
			guard_wr_data <= wr_data;
		end
	end

endmodule

//--- tb_mem_access.sv
module tb_mem_access
	import mem_access_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int ROW_COUNT = 40;
	localparam int ROW_CYCLES = 40; // Watchdog budget per row.
	localparam int WAIT_LIMIT = 30;
	localparam int QUIET_CYCLES = 8;

	typedef enum {OP_WRITE, OP_READ, OP_BOTH, OP_READ_AGAIN} op_kind_t;

	logic clk;
	logic arst_n;
	logic req_read;
	cpu_addr_t rd_addr;
	logic rd_busy;
	logic rd_valid;
	line_data_t rd_data;
	logic req_write;
	cpu_addr_t wr_addr;
	line_data_t wr_data;
	logic wr_busy;
	logic wr_done;

	op_kind_t op_kind [ROW_COUNT];
	cpu_addr_t op_addr [ROW_COUNT];
	line_data_t op_data [ROW_COUNT];
	int row_count;

	line_data_t shadow [LINE_COUNT]; // Expected store contents.
	int errors;
	int timeouts;
	int assert_fails;

	mem_access_top i_mem_access_top
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.req_read  (req_read),
		.rd_addr   (rd_addr),
		.rd_busy   (rd_busy),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data),
		.req_write (req_write),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_busy   (wr_busy),
		.wr_done   (wr_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		repeat (RESET_CYCLES + ROW_COUNT * ROW_CYCLES) @(posedge clk);
		$display("Watchdog expired before all table rows finished.");
		$display(">>> FAIL");
		$finish;
	end

	// **************************************************
	// Helpers
	// **************************************************

	function automatic line_data_t random_line();
		line_data_t l;
		for (int w = 0; w < 8; w++)
			l[w*32 +: 32] = $urandom;
		return l;
	endfunction

	// Bits 8 to 5 pick the line.
	function automatic line_index_t line_number(input cpu_addr_t addr);
		return addr[8:5];
	endfunction

	task automatic add_row(input op_kind_t kind, input cpu_addr_t addr, input line_data_t data);
		op_kind[row_count] = kind;
		op_addr[row_count] = addr;
		op_data[row_count] = data;
		row_count++;
	endtask

	task automatic build_table();
		add_row(OP_READ, 32'h0000_0000, '0); // Store is clear after reset.
		add_row(OP_READ, 32'h0000_0127, '0);
		add_row(OP_READ, 32'h0000_01E0, '0);
		add_row(OP_WRITE, 32'h0000_0040, random_line());
		add_row(OP_READ, 32'h0000_005F, '0); // Same line, other byte.
		add_row(OP_BOTH, 32'h0000_0041, random_line());
		add_row(OP_READ, 32'h0000_0048, '0);
		add_row(OP_READ_AGAIN, 32'h0000_0044, '0);
		for (int i = 0; i < LINE_COUNT; i++)
			add_row(OP_WRITE, cpu_addr_t'(i * 32 + 3), random_line());
		for (int i = 0; i < LINE_COUNT; i++)
			add_row(OP_READ, cpu_addr_t'((15 - i) * 32 + 17), '0);
	endtask

	task automatic report_bit(input string name, input logic got, input logic exp);
		errors++;
		$display("[ERROR] %s got %h expected %h", name, got, exp);
	endtask

	task automatic report_line(input string name, input line_data_t got, input line_data_t exp);
		errors++;
		$display("[ERROR] %s got %h expected %h", name, got, exp);
	endtask

	// **************************************************
	// One table row
	// **************************************************

	task automatic run_row(input int r);
		logic want_rd;
		logic want_wr;
		logic got_rd;
		logic got_wr;
		line_data_t expect_rd;
		line_index_t idx;
		int cycles;

		idx = line_number(op_addr[r]);
		want_rd = (op_kind[r] != OP_WRITE);
		want_wr = (op_kind[r] == OP_WRITE) || (op_kind[r] == OP_BOTH);
		got_rd = !want_rd;
		got_wr = !want_wr;
		expect_rd = shadow[idx]; // Read wins, so it sees the old line.

		req_read = want_rd;
		rd_addr = op_addr[r];
		req_write = want_wr;
		wr_addr = op_addr[r];
		wr_data = op_data[r];
		@(posedge clk);
		#1;
		req_read = 1'b0;
		req_write = 1'b0;

		cycles = 0;
		while (!(got_rd && got_wr) && (cycles < WAIT_LIMIT))
		begin
			if (!got_rd)
			begin
				if (rd_valid === 1'b1)
				begin
					got_rd = 1'b1;
					if (rd_busy !== 1'b0)
						report_bit("rd_busy", rd_busy, 1'b0);
					if (rd_data !== expect_rd)
						report_line("rd_data", rd_data, expect_rd);
				end
				else if (rd_busy !== 1'b1)
					report_bit("rd_busy", rd_busy, 1'b1);
			end
			if (!got_wr)
			begin
				if (wr_done === 1'b1)
				begin
					got_wr = 1'b1;
					if (wr_busy !== 1'b0)
						report_bit("wr_busy", wr_busy, 1'b0);
				end
				else if (wr_busy !== 1'b1)
					report_bit("wr_busy", wr_busy, 1'b1);
			end
			// Second request to the next line while still busy.
			if (op_kind[r] == OP_READ_AGAIN)
			begin
				req_read = (cycles == 1);
				rd_addr = op_addr[r] + 32'h20;
			end
			if (!(got_rd && got_wr))
			begin
				@(posedge clk);
				#1;
				cycles++;
			end
		end
		req_read = 1'b0;

		if (!(got_rd && got_wr))
		begin
			timeouts++;
			$display("Row %0d did not complete within %0d cycles.", r, WAIT_LIMIT);
		end

		// Exactly one pulse per request.
		repeat (QUIET_CYCLES)
		begin
			@(posedge clk);
			#1;
			if (rd_valid !== 1'b0)
				report_bit("rd_valid", rd_valid, 1'b0);
			if (wr_done !== 1'b0)
				report_bit("wr_done", wr_done, 1'b0);
			if (rd_busy !== 1'b0)
				report_bit("rd_busy", rd_busy, 1'b0);
			if (wr_busy !== 1'b0)
				report_bit("wr_busy", wr_busy, 1'b0);
		end

		if (want_wr)
			shadow[idx] = op_data[r];
	endtask

	initial
	begin
		void'($urandom(66174));
		arst_n = 1'b0;
		req_read = 1'b0;
		rd_addr = '0;
		req_write = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		errors = 0;
		timeouts = 0;
		row_count = 0;
		for (int i = 0; i < LINE_COUNT; i++)
			shadow[i] = '0;
		build_table();

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;
		if (rd_busy !== 1'b0)
			report_bit("rd_busy", rd_busy, 1'b0);
		if (wr_busy !== 1'b0)
			report_bit("wr_busy", wr_busy, 1'b0);
		if (rd_valid !== 1'b0)
			report_bit("rd_valid", rd_valid, 1'b0);
		if (wr_done !== 1'b0)
			report_bit("wr_done", wr_done, 1'b0);

		for (int r = 0; r < row_count; r++)
			run_row(r);

		assert_fails = i_mem_access_top.i_mem_access_properties.fail_count;
		$display("Value errors: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts, assert_fails);
		if ((errors == 0) && (timeouts == 0) && (assert_fails == 0))
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
